//--- hw/rv32i_types.sv
package rv32i_types;

    // datapath widths
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // operand source selects from the forwarding unit
    localparam logic [1:0] FWD_REG = 2'd0;
    localparam logic [1:0] FWD_WB  = 2'd1;
    localparam logic [1:0] FWD_MEM = 2'd2;

    // rv32i major opcodes handled by this slice
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } opcode_t;

    // funct3 encoding, alu_mod picks sub / sra
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_op_t;

    // branch funct3 encoding
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef struct packed {
        logic                 valid;
        logic                 regf_we;
        logic                 mem_read;
        logic [REG_IDX_W-1:0] rd_s;
        logic [XLEN-1:0]      alu_result;
    } ex_mem_t;

    typedef struct packed {
        logic                 valid;
        logic                 regf_we;
        logic [REG_IDX_W-1:0] rd_s;
        logic [XLEN-1:0]      rd_v;
    } mem_wb_t;

endpackage

//--- hw/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit
import rv32i_types::*;
(
    input   logic   [REG_IDX_W-1:0] rs1_s,
    input   logic   [REG_IDX_W-1:0] rs2_s,
    input   logic   [REG_IDX_W-1:0] mem_rd_s,
    input   logic   [REG_IDX_W-1:0] wb_rd_s,
    input   logic                   mem_writeback,
    input   logic                   wb_writeback,
    output  logic   [1:0]           r1_sel,
    output  logic   [1:0]           r2_sel
);

    // younger result in MEM beats the one in WB
    // x0 is hardwired and never forwards
    function automatic logic [1:0] pick_source(input logic [REG_IDX_W-1:0] src);
        logic [1:0] sel;
        sel = FWD_REG;
        if (src != '0)
        begin
            if (mem_writeback && (mem_rd_s == src))
                sel = FWD_MEM;
            else if (wb_writeback && (wb_rd_s == src))
                sel = FWD_WB;
        end
        return sel;
    endfunction

    always_comb
    begin : select_sources
        r1_sel = pick_source(rs1_s);
        r2_sel = pick_source(rs2_s);
    end : select_sources

endmodule

//--- hw/pipeline_alu.sv
`timescale 1ns/1ps

module pipeline_alu
import rv32i_types::*;
(
    input   logic   [XLEN-1:0]  a,
    input   logic   [XLEN-1:0]  b,
    input   alu_op_t            alu_op,
    input   logic               alu_mod,
    input   cmp_op_t            cmp_op,
    input   logic               alu_or_cmp,
    output  logic   [XLEN-1:0]  f
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] arith;
    logic            cmp_true;

    assign shamt = b[4:0];

    always_comb
    begin : compute
        case (cmp_op)
            cmp_beq:  cmp_true = (a == b);
            cmp_bne:  cmp_true = (a != b);
            cmp_blt:  cmp_true = ($signed(a) < $signed(b));
            cmp_bge:  cmp_true = ($signed(a) >= $signed(b));
            cmp_bltu: cmp_true = (a < b);
            cmp_bgeu: cmp_true = (a >= b);
            default:  cmp_true = 1'b0;
        endcase

        unique case (alu_op)
            alu_add:
                begin
                    if (alu_mod)
                        arith = a - b;
                    else
                        arith = a + b;
                end
            alu_sll:  arith = a << shamt;
            alu_slt:  arith = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            alu_sltu: arith = {{(XLEN-1){1'b0}}, (a < b)};
            alu_xor:  arith = a ^ b;
            alu_srl:
                begin
                    // sra when alu_mod is set
                    if (alu_mod)
                        arith = $signed(a) >>> shamt;
                    else
                        arith = a >> shamt;
                end
            alu_or:   arith = a | b;
            alu_and:  arith = a & b;
        endcase

        // branch compare lands in bit 0
        f = alu_or_cmp ? {{(XLEN-1){1'b0}}, cmp_true} : arith;
    end : compute

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
import rv32i_types::*;
(
    input   logic                   clk,
    input   logic                   reset,

    // decoded instruction
    input   logic                   valid,
    input   opcode_t                opcode,
    input   logic   [XLEN-1:0]      pc,
    input   logic   [REG_IDX_W-1:0] rs1_s,
    input   logic   [REG_IDX_W-1:0] rs2_s,
    input   logic   [XLEN-1:0]      rs1_v,
    input   logic   [XLEN-1:0]      rs2_v,
    input   logic   [XLEN-1:0]      imm,
    input   logic                   alu_src,
    input   alu_op_t                alu_op,
    input   logic                   alu_mod,
    input   logic                   alu_or_cmp,
    input   cmp_op_t                cmp_op,
    input   logic                   branch,
    input   logic                   jal,
    input   logic                   jalr,
    input   logic                   stall,

    // older instructions
    input   logic   [REG_IDX_W-1:0] mem_rd_s,
    input   logic                   mem_writeback,
    input   logic                   mem_is_load,
    input   logic   [XLEN-1:0]      mem_result,
    input   logic   [XLEN-1:0]      ld_forward_val,
    input   logic   [REG_IDX_W-1:0] wb_rd_s,
    input   logic                   wb_writeback,
    input   logic   [XLEN-1:0]      wb_result,

    output  logic                   br_en,
    output  logic   [XLEN-1:0]      redirect_pc,
    output  logic   [XLEN-1:0]      ex_result,
    output  logic                   ex_valid
);

    logic [1:0]      r1_sel;
    logic [1:0]      r2_sel;
    logic [XLEN-1:0] mem_fwd_val;
    logic [XLEN-1:0] r1_val;
    logic [XLEN-1:0] r2_val;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] f;
    logic            jump;

    forwarding_unit fwd_unit (
        .rs1_s         (rs1_s),
        .rs2_s         (rs2_s),
        .mem_rd_s      (mem_rd_s),
        .wb_rd_s       (wb_rd_s),
        .mem_writeback (mem_writeback),
        .wb_writeback  (wb_writeback),
        .r1_sel        (r1_sel),
        .r2_sel        (r2_sel)
    );

    // a load in MEM hands over its data, not its address
    assign mem_fwd_val = mem_is_load ? ld_forward_val : mem_result;

    always_comb
    begin : operand_select
        case (r1_sel)
            FWD_WB:  r1_val = wb_result;
            FWD_MEM: r1_val = mem_fwd_val;
            default: r1_val = rs1_v;
        endcase

        case (r2_sel)
            FWD_WB:  r2_val = wb_result;
            FWD_MEM: r2_val = mem_fwd_val;
            default: r2_val = rs2_v;
        endcase

        case (opcode)
            op_b_lui:                      a = '0;
            op_b_auipc, op_b_jal, op_b_jalr: a = pc;
            default:                       a = r1_val;
        endcase

        b = alu_src ? imm : r2_val;
    end : operand_select

    pipeline_alu alu (
        .a          (a),
        .b          (b),
        .alu_op     (alu_op),
        .alu_mod    (alu_mod),
        .cmp_op     (cmp_op),
        .alu_or_cmp (alu_or_cmp),
        .f          (f)
    );

    assign jump = jal | jalr;

    // jalr target drops bit 0
    assign redirect_pc = jalr ? ((r1_val + imm) & ~32'h1) : (pc + imm);
    assign br_en       = valid & ~stall & (jump | (branch & f[0]));

    // jumps link pc+4
    assign ex_result = jump ? (pc + 32'd4) : f;
    assign ex_valid  = valid & ~stall;

    // a stalled instruction stays at the issue port
    assert property (@(posedge clk) disable iff (reset)
        (valid && stall) |=> (valid && $stable(pc) && $stable(opcode)));

endmodule

//--- hw/stage_reg.sv
`timescale 1ns/1ps

module stage_reg
#(
    parameter type payload_t       = logic,
    parameter bit  BUBBLE_ON_STALL = 1'b0
)
(
    input   logic       clk,
    input   logic       reset,
    input   logic       stall,
    input   payload_t   d,
    output  payload_t   q
);

    // bubble clears the whole payload including valid
    always_ff @(posedge clk)
    begin
        if (reset || (BUBBLE_ON_STALL && stall))
            q <= '0;
        else
            q <= d;
    end

endmodule

//--- hw/ex_pipe.sv
`timescale 1ns/1ps

module ex_pipe
import rv32i_types::*;
(
    input   logic                   clk,
    input   logic                   reset,

    // issue side from decode
    input   logic                   valid,
    input   opcode_t                opcode,
    input   logic   [XLEN-1:0]      pc,
    input   logic   [REG_IDX_W-1:0] rs1_s,
    input   logic   [REG_IDX_W-1:0] rs2_s,
    input   logic   [XLEN-1:0]      rs1_v,
    input   logic   [XLEN-1:0]      rs2_v,
    input   logic   [XLEN-1:0]      imm,
    input   logic                   alu_src,
    input   alu_op_t                alu_op,
    input   logic                   alu_mod,
    input   logic                   alu_or_cmp,
    input   cmp_op_t                cmp_op,
    input   logic                   branch,
    input   logic                   jal,
    input   logic                   jalr,
    input   logic                   regf_we,
    input   logic                   is_load,
    input   logic   [REG_IDX_W-1:0] rd_s,
    input   logic                   stall,

    output  logic                   br_en,
    output  logic   [XLEN-1:0]      redirect_pc,

    // data memory read port
    output  logic                   mem_read,
    output  logic   [XLEN-1:0]      mem_addr,
    input   logic   [XLEN-1:0]      mem_rdata,

    output  logic                   wb_valid,
    output  logic                   wb_we,
    output  logic   [REG_IDX_W-1:0] wb_rd,
    output  logic   [XLEN-1:0]      wb_data
);

    logic [XLEN-1:0] ex_result;
    logic            ex_valid;
    ex_mem_t         ex_mem_d;
    ex_mem_t         ex_mem_q;
    mem_wb_t         mem_wb_d;
    mem_wb_t         mem_wb_q;

    ex_stage ex (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .opcode         (opcode),
        .pc             (pc),
        .rs1_s          (rs1_s),
        .rs2_s          (rs2_s),
        .rs1_v          (rs1_v),
        .rs2_v          (rs2_v),
        .imm            (imm),
        .alu_src        (alu_src),
        .alu_op         (alu_op),
        .alu_mod        (alu_mod),
        .alu_or_cmp     (alu_or_cmp),
        .cmp_op         (cmp_op),
        .branch         (branch),
        .jal            (jal),
        .jalr           (jalr),
        .stall          (stall),
        .mem_rd_s       (ex_mem_q.rd_s),
        .mem_writeback  (ex_mem_q.valid & ex_mem_q.regf_we),
        .mem_is_load    (mem_read),
        .mem_result     (ex_mem_q.alu_result),
        .ld_forward_val (mem_rdata),
        .wb_rd_s        (mem_wb_q.rd_s),
        .wb_writeback   (mem_wb_q.valid & mem_wb_q.regf_we),
        .wb_result      (mem_wb_q.rd_v),
        .br_en          (br_en),
        .redirect_pc    (redirect_pc),
        .ex_result      (ex_result),
        .ex_valid       (ex_valid)
    );

    assign ex_mem_d.valid      = ex_valid;
    assign ex_mem_d.regf_we    = regf_we;
    assign ex_mem_d.mem_read   = is_load;
    assign ex_mem_d.rd_s       = rd_s;
    assign ex_mem_d.alu_result = ex_result;

    // stall turns EX/MEM into a bubble
    stage_reg #(.payload_t(ex_mem_t), .BUBBLE_ON_STALL(1'b1)) ex_mem_reg (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // memory stage, read answered in the same cycle
    assign mem_read = ex_mem_q.valid & ex_mem_q.mem_read;
    assign mem_addr = ex_mem_q.alu_result;

    assign mem_wb_d.valid   = ex_mem_q.valid;
    assign mem_wb_d.regf_we = ex_mem_q.regf_we;
    assign mem_wb_d.rd_s    = ex_mem_q.rd_s;
    assign mem_wb_d.rd_v    = ex_mem_q.mem_read ? mem_rdata : ex_mem_q.alu_result;

    // MEM/WB keeps draining under stall
    stage_reg #(.payload_t(mem_wb_t), .BUBBLE_ON_STALL(1'b0)) mem_wb_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    assign wb_valid = mem_wb_q.valid;
    assign wb_we    = mem_wb_q.regf_we;
    assign wb_rd    = mem_wb_q.rd_s;
    assign wb_data  = mem_wb_q.rd_v;

    // issued instruction retires exactly two cycles later
    assert property (@(posedge clk) disable iff (reset) (valid && !stall) |=> ##1 wb_valid);

endmodule

//--- verification/ex_pipe_tb.sv
`timescale 1ns/1ps

module ex_pipe_tb
import rv32i_types::*;
();

    typedef struct packed {
        int          stamp;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_entry_t;

    logic        clk;
    logic        reset;
    logic        valid;
    opcode_t     opcode;
    logic [31:0] pc;
    logic [4:0]  rs1_s;
    logic [4:0]  rs2_s;
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;
    logic [31:0] imm;
    logic        alu_src;
    alu_op_t     alu_op;
    logic        alu_mod;
    logic        alu_or_cmp;
    cmp_op_t     cmp_op;
    logic        branch;
    logic        jal;
    logic        jalr;
    logic        regf_we;
    logic        is_load;
    logic [4:0]  rd_s;
    logic        stall;
    logic        br_en;
    logic [31:0] redirect_pc;
    logic        mem_read;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic        wb_valid;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // expected values for the current cycle
    logic        exp_br_en;
    logic [31:0] exp_redirect;
    logic        exp_mem_read;
    logic [31:0] exp_mem_addr;
    logic        next_mem_read;
    logic [31:0] next_mem_addr;
    logic        exp_wb_valid;
    logic        exp_wb_we;
    logic [4:0]  exp_wb_rd;
    logic [31:0] exp_wb_data;

    // rf_arch is what the register file holds
    // rf_spec also includes in-flight results
    logic [31:0] rf_arch [32];
    logic [31:0] rf_spec [32];
    wb_entry_t   exp_q[$];
    logic [31:0] pc_count;
    logic [31:0] rnd;
    integer      seed;
    int          cycle;
    int          fail_count;
    int          wait_cnt;
    alu_op_t     rop;
    cmp_op_t     c;

    ex_pipe i_dut (.*);

    always #4 clk = ~clk;

    // word pattern mixes every address bit
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[7:0], addr[31:8]} ^ 32'hc3a5_5a3c;
    endfunction

    assign mem_rdata = mem_word(mem_addr);

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return {2'b00, r[2:0]};
    endfunction

    function automatic logic signed_less(input logic [31:0] x, input logic [31:0] y);
        // differing signs decide directly
        if (x[31] != y[31])
            return x[31];
        return x < y;
    endfunction

    function automatic logic [31:0] alu_ref(input alu_op_t op, input logic md,
                                            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (op)
            alu_add:  r = md ? (x - y) : (x + y);
            alu_sll:  r = x << y[4:0];
            alu_slt:  r = {31'b0, signed_less(x, y)};
            alu_sltu: r = {31'b0, x < y};
            alu_xor:  r = x ^ y;
            alu_srl:
                begin
                    r = x >> y[4:0];
                    if (md)
                        r = r | ((~(32'hffff_ffff >> y[4:0])) & {32{x[31]}});
                end
            alu_or:   r = x | y;
            default:  r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input cmp_op_t cmp, input logic [31:0] x,
                                          input logic [31:0] y);
        case (cmp)
            cmp_beq:  return x == y;
            cmp_bne:  return x != y;
            cmp_blt:  return signed_less(x, y);
            cmp_bge:  return !signed_less(x, y);
            cmp_bltu: return x < y;
            default:  return x >= y;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        fail_count = fail_count + 1;
        $display("ERR %s exp 0x%08h got 0x%08h", name, exp_v, got_v);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // checks sampled mid-cycle where outputs are settled
    check_br_en: assert property (@(negedge clk) disable iff (reset) br_en == exp_br_en)
        else report_mismatch("br_en", 32'(exp_br_en), 32'(br_en));
    check_redirect: assert property (@(negedge clk) disable iff (reset)
        exp_br_en |-> (redirect_pc == exp_redirect))
        else report_mismatch("redirect_pc", exp_redirect, redirect_pc);
    check_mem_read: assert property (@(negedge clk) disable iff (reset)
        mem_read == exp_mem_read)
        else report_mismatch("mem_read", 32'(exp_mem_read), 32'(mem_read));
    check_mem_addr: assert property (@(negedge clk) disable iff (reset)
        exp_mem_read |-> (mem_addr == exp_mem_addr))
        else report_mismatch("mem_addr", exp_mem_addr, mem_addr);
    check_wb_valid: assert property (@(negedge clk) disable iff (reset)
        wb_valid == exp_wb_valid)
        else report_mismatch("wb_valid", 32'(exp_wb_valid), 32'(wb_valid));
    check_wb_rd: assert property (@(negedge clk) disable iff (reset)
        exp_wb_valid |-> (wb_rd == exp_wb_rd))
        else report_mismatch("wb_rd", 32'(exp_wb_rd), 32'(wb_rd));
    check_wb_we: assert property (@(negedge clk) disable iff (reset)
        exp_wb_valid |-> (wb_we == exp_wb_we))
        else report_mismatch("wb_we", 32'(exp_wb_we), 32'(wb_we));
    check_wb_data: assert property (@(negedge clk) disable iff (reset)
        (exp_wb_valid && exp_wb_we) |-> (wb_data == exp_wb_data))
        else report_mismatch("wb_data", exp_wb_data, wb_data);

    task automatic clear_inputs();
        valid = 1'b0;
        opcode = op_b_imm;
        pc = 32'h0;
        rs1_s = 5'd0;
        rs2_s = 5'd0;
        rs1_v = 32'h0;
        rs2_v = 32'h0;
        imm = 32'h0;
        alu_src = 1'b0;
        alu_op = alu_add;
        alu_mod = 1'b0;
        alu_or_cmp = 1'b0;
        cmp_op = cmp_beq;
        branch = 1'b0;
        jal = 1'b0;
        jalr = 1'b0;
        regf_we = 1'b0;
        is_load = 1'b0;
        rd_s = 5'd0;
        stall = 1'b0;
    endtask

    // advance to the next drive point and roll the expected state forward
    task automatic next_cycle();
        @(posedge clk);
        #1;
        cycle = cycle + 1;
        if (exp_wb_valid && exp_wb_we && (exp_wb_rd != 5'd0))
            rf_arch[exp_wb_rd] = exp_wb_data;
        exp_wb_valid = 1'b0;
        exp_wb_we = 1'b0;
        if ((exp_q.size() > 0) && (exp_q[0].stamp == cycle))
        begin
            exp_wb_valid = 1'b1;
            exp_wb_we = exp_q[0].we;
            exp_wb_rd = exp_q[0].rd;
            exp_wb_data = exp_q[0].data;
            void'(exp_q.pop_front());
        end
        exp_mem_read = next_mem_read;
        exp_mem_addr = next_mem_addr;
        next_mem_read = 1'b0;
        exp_br_en = 1'b0;
        clear_inputs();
    endtask

    // register values lag by two instructions so forwarding is needed
    task automatic present_sources(input logic [4:0] r1, input logic [4:0] r2);
        valid = 1'b1;
        pc = pc_count;
        rs1_s = r1;
        rs2_s = r2;
        rs1_v = rf_arch[r1];
        rs2_v = rf_arch[r2];
    endtask

    task automatic commit_issue(input logic we, input logic [4:0] rd,
                                input logic [31:0] result);
        wb_entry_t e;
        e.stamp = cycle + 2;
        e.we = we;
        e.rd = rd;
        e.data = result;
        exp_q.push_back(e);
        if (we && (rd != 5'd0))
            rf_spec[rd] = result;
        pc_count = pc_count + 32'd4;
    endtask

    task automatic alu_instr(input alu_op_t op, input logic md, input logic use_imm,
                             input logic [4:0] r1, input logic [4:0] r2,
                             input logic [4:0] rd, input logic [31:0] imm_v);
        logic [31:0] b_v;
        next_cycle();
        present_sources(r1, r2);
        b_v = use_imm ? imm_v : rf_spec[r2];
        opcode = use_imm ? op_b_imm : op_b_reg;
        imm = imm_v;
        alu_src = use_imm;
        alu_op = op;
        alu_mod = md;
        regf_we = 1'b1;
        rd_s = rd;
        commit_issue(1'b1, rd, alu_ref(op, md, rf_spec[r1], b_v));
    endtask

    task automatic upper_instr(input logic is_auipc, input logic [4:0] rd,
                               input logic [31:0] imm_v);
        next_cycle();
        present_sources(5'd0, 5'd0);
        opcode = is_auipc ? op_b_auipc : op_b_lui;
        imm = imm_v;
        alu_src = 1'b1;
        regf_we = 1'b1;
        rd_s = rd;
        commit_issue(1'b1, rd, is_auipc ? (pc_count + imm_v) : imm_v);
    endtask

    task automatic load_instr(input logic [4:0] r1, input logic [4:0] rd,
                              input logic [31:0] off);
        next_cycle();
        present_sources(r1, 5'd0);
        opcode = op_b_load;
        imm = off;
        alu_src = 1'b1;
        regf_we = 1'b1;
        is_load = 1'b1;
        rd_s = rd;
        next_mem_read = 1'b1;
        next_mem_addr = rf_spec[r1] + off;
        commit_issue(1'b1, rd, mem_word(rf_spec[r1] + off));
    endtask

    task automatic branch_instr(input cmp_op_t cmp, input logic [4:0] r1,
                                input logic [4:0] r2, input logic [31:0] off);
        next_cycle();
        present_sources(r1, r2);
        opcode = op_b_br;
        imm = off;
        alu_or_cmp = 1'b1;
        cmp_op = cmp;
        branch = 1'b1;
        exp_br_en = branch_taken(cmp, rf_spec[r1], rf_spec[r2]);
        exp_redirect = pc_count + off;
        commit_issue(1'b0, 5'd0, {31'b0, exp_br_en});
    endtask

    task automatic jump_instr(input logic is_jalr, input logic [4:0] r1,
                              input logic [4:0] rd, input logic [31:0] off);
        next_cycle();
        present_sources(r1, 5'd0);
        opcode = is_jalr ? op_b_jalr : op_b_jal;
        jal = !is_jalr;
        jalr = is_jalr;
        imm = off;
        alu_src = 1'b1;
        regf_we = 1'b1;
        rd_s = rd;
        exp_br_en = 1'b1;
        exp_redirect = is_jalr ? ((rf_spec[r1] + off) & ~32'h1) : (pc_count + off);
        commit_issue(1'b1, rd, pc_count + 32'd4);
    endtask

    // jal held at the issue port under stall
    task automatic stall_cycle();
        next_cycle();
        present_sources(5'd0, 5'd0);
        opcode = op_b_jal;
        jal = 1'b1;
        imm = 32'h40;
        alu_src = 1'b1;
        regf_we = 1'b1;
        rd_s = 5'd3;
        stall = 1'b1;
    endtask

    initial
    begin
        seed = 85112;
        clk = 1'b0;
        reset = 1'b1;
        cycle = 0;
        fail_count = 0;
        pc_count = 32'h0000_1000;
        exp_br_en = 1'b0;
        exp_redirect = 32'h0;
        exp_mem_read = 1'b0;
        exp_mem_addr = 32'h0;
        next_mem_read = 1'b0;
        next_mem_addr = 32'h0;
        exp_wb_valid = 1'b0;
        exp_wb_we = 1'b0;
        exp_wb_rd = 5'd0;
        exp_wb_data = 32'h0;
        clear_inputs();
        rf_arch[0] = 32'h0;
        rf_spec[0] = 32'h0;
        for (int i = 1; i < 32; i++)
        begin
            rf_arch[i] = $random(seed);
            rf_spec[i] = rf_arch[i];
        end

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // quiet pipeline after reset
        repeat (4) next_cycle();

        // MEM and WB forwarding with MEM winning over WB
        alu_instr(alu_add, 1'b0, 1'b1, 5'd0, 5'd0, 5'd5, 32'h123);
        alu_instr(alu_add, 1'b0, 1'b1, 5'd5, 5'd0, 5'd6, 32'h10);
        alu_instr(alu_add, 1'b1, 1'b0, 5'd5, 5'd6, 5'd7, 32'h0);
        alu_instr(alu_add, 1'b0, 1'b1, 5'd0, 5'd0, 5'd9, 32'h111);
        alu_instr(alu_add, 1'b0, 1'b1, 5'd0, 5'd0, 5'd9, 32'h222);
        alu_instr(alu_add, 1'b0, 1'b1, 5'd9, 5'd0, 5'd10, 32'h1);

        // writes to x0 are never forwarded
        alu_instr(alu_add, 1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 32'h55);
        alu_instr(alu_or, 1'b0, 1'b0, 5'd0, 5'd0, 5'd11, 32'h0);

        // load followed by consumers at distance one and two
        alu_instr(alu_add, 1'b0, 1'b1, 5'd0, 5'd0, 5'd12, 32'h400);
        load_instr(5'd12, 5'd13, 32'h8);
        alu_instr(alu_add, 1'b0, 1'b0, 5'd13, 5'd13, 5'd14, 32'h0);
        alu_instr(alu_xor, 1'b0, 1'b0, 5'd13, 5'd14, 5'd15, 32'h0);

        // every compare on equal, mixed and sign-differing operands
        upper_instr(1'b0, 5'd16, 32'h8000_0000);
        c = c.first();
        for (int i = 0; i < 6; i++)
        begin
            branch_instr(c, 5'd5, 5'd5, 32'h20);
            branch_instr(c, 5'd5, 5'd7, 32'hffff_fff0);
            branch_instr(c, 5'd16, 5'd5, 32'h0000_0100);
            c = c.next();
        end

        // jal links pc+4
        // jalr target from a forwarded base with bit 0 dropped
        jump_instr(1'b0, 5'd0, 5'd1, 32'h100);
        jump_instr(1'b1, 5'd1, 5'd2, 32'h7);
        alu_instr(alu_add, 1'b0, 1'b0, 5'd2, 5'd1, 5'd4, 32'h0);

        // two stall cycles while older instructions drain
        alu_instr(alu_add, 1'b0, 1'b1, 5'd4, 5'd0, 5'd20, 32'h3);
        alu_instr(alu_sll, 1'b0, 1'b1, 5'd20, 5'd0, 5'd21, 32'h4);
        stall_cycle();
        stall_cycle();
        jump_instr(1'b0, 5'd0, 5'd3, 32'h40);

        for (int i = 0; i < 120; i++)
        begin
            rnd = $random(seed);
            rop = alu_op_t'(rnd[6:4]);
            case (rnd[3:0])
                4'd0: upper_instr(1'b0, pick_reg(), {rnd[31:12], 12'h000});
                4'd1: upper_instr(1'b1, pick_reg(), {rnd[31:12], 12'h000});
                4'd2: load_instr(pick_reg(), pick_reg(), sext12(rnd[27:16]));
                4'd3:
                    begin
                        stall_cycle();
                        jump_instr(1'b0, 5'd0, 5'd3, 32'h40);
                    end
                4'd4: branch_instr(cmp_op_t'(rnd[6:4] | 3'b100), pick_reg(), pick_reg(),
                                   sext12(rnd[27:16]));
                4'd5, 4'd6, 4'd7:
                    alu_instr(rop, rnd[7] && (rop == alu_srl), 1'b1, pick_reg(),
                              5'd0, pick_reg(), sext12(rnd[27:16]));
                default:
                    alu_instr(rop, rnd[7] && ((rop == alu_srl) || (rop == alu_add)),
                              1'b0, pick_reg(), pick_reg(), pick_reg(), 32'h0);
            endcase
        end

        wait_cnt = 0;
        while ((exp_q.size() != 0) && (wait_cnt < 10))
        begin
            next_cycle();
            wait_cnt = wait_cnt + 1;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout: expected writebacks never drained from the pipeline");
            $display("TEST FAILED");
            $fatal(1);
        end
        next_cycle();
        @(negedge clk);
        #1;

        if (fail_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- ex_pipe.f
hw/rv32i_types.sv
hw/forwarding_unit.sv
hw/pipeline_alu.sv
hw/ex_stage.sv
hw/stage_reg.sv
hw/ex_pipe.sv
verification/ex_pipe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ex_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module ex_pipe_tb -f ex_pipe.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vex_pipe_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
